// File: project.f
+incdir+logic
logic/pp_isa_pkg.sv
logic/pp_ctrl_pkg.sv
logic/pp_sequencer.sv
logic/pp_regfile.sv
logic/pp_checksum.sv
logic/pp_alu.sv
logic/packet_processor.sv
verification/packet_checker.sv
verification/packet_processor_tb.sv

// File: run.sh
#!/bin/sh
# build and run the packet processor testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -f project.f \
	--top-module packet_processor_tb -Mdir obj_dir -o packet_processor_sim
output=$(./obj_dir/packet_processor_sim)
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx 'Test passed'
then
	echo "simulation result: pass"
else
	echo "simulation result: fail"
	exit 1
fi

// File: verification/packet_processor_tb.sv
//////////////////////////////////////////////////////////////////////
// packet processor testbench
// drives a table of frames with random stalls on both sides
//////////////////////////////////////////////////////////////////////

`default_nettype none

module packet_processor_tb;
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [7:0] hdr;
		logic [7:0] len; // payload bytes, even
		logic [7:0] base; // first payload byte
		logic [7:0] step; // added per byte
		logic rnd; // random payload instead of base/step
		logic pause; // en low before the frame
	} frame_t;

	localparam int num_frames = 10;
	localparam frame_t frames [num_frames] = '{
		'{8'h3A, 8'd4, 8'h01, 8'h01, 1'b0, 1'b0},
		'{8'hFF, 8'd6, 8'h10, 8'h03, 1'b0, 1'b0}, // dropped
		'{8'h5C, 8'd2, 8'hAB, 8'h00, 1'b0, 1'b0}, // shortest payload
		'{8'h12, 8'd8, 8'hFF, 8'h00, 1'b0, 1'b0}, // all ff, carry wraps
		'{8'hFF, 8'd2, 8'hFF, 8'h00, 1'b0, 1'b0},
		'{8'h7E, 8'd10, 8'h00, 8'h00, 1'b1, 1'b1},
		'{8'hC4, 8'd16, 8'h00, 8'h00, 1'b1, 1'b0},
		'{8'hEF, 8'd6, 8'hF0, 8'h07, 1'b0, 1'b0},
		'{8'hA5, 8'd12, 8'h00, 8'h00, 1'b1, 1'b1},
		'{8'hF0, 8'd20, 8'h00, 8'h00, 1'b1, 1'b0}
	};

	logic clk = 1'b0;
	logic rst;
	logic en;
	logic in_sof;
	logic in_eof;
	logic in_src_rdy;
	logic [7:0] in_data;
	logic out_dst_rdy;
	wire in_dst_rdy;
	wire out_sof;
	wire out_eof;
	wire out_src_rdy;
	wire [7:0] out_data;
	wire [3:0] outport_addr;
	wire [3:0] inport_addr;
	int value_errors;
	int other_errors;
	int out_count;
	int pending;
	int local_errors = 0;
	int expected_out; // output bytes of all kept frames
	int cycle_limit;
	int cycle_count = 0;

	always #4 clk = ~clk; // 8 ns period

	packet_processor packet_processor_inst (
		.clk, .rst, .en, .in_sof, .in_eof, .in_src_rdy, .in_dst_rdy, .in_data,
		.out_sof, .out_eof, .out_src_rdy, .out_dst_rdy, .out_data,
		.outport_addr, .inport_addr
	);

	packet_checker packet_checker_inst (
		.clk, .rst, .en, .in_sof, .in_eof, .in_src_rdy, .in_dst_rdy, .in_data,
		.out_sof, .out_eof, .out_src_rdy, .out_dst_rdy, .out_data,
		.outport_addr, .inport_addr, .value_errors, .other_errors, .out_count, .pending
	);

	task automatic finish_run(input logic timed_out);
		$display("errors: %0d wrong values, %0d other", value_errors,
			other_errors + local_errors);
		if (!timed_out && value_errors == 0 && other_errors + local_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	endtask

	// present one byte, after an optional gap, until it is taken
	task automatic send_byte(input logic [7:0] data, input logic sof, input logic eof);
		int unsigned gap;
		logic accepted;
		gap = ($urandom % 4 == 0) ? 1 + $urandom % 3 : 0;
		if (gap != 0)
		begin
			in_src_rdy <= 1'b0;
			repeat (gap) @(posedge clk);
		end
		in_data <= data;
		in_sof <= sof;
		in_eof <= eof;
		in_src_rdy <= 1'b1;
		do
		begin
			@(negedge clk);
			accepted = in_src_rdy && in_dst_rdy;
			@(posedge clk);
		end
		while (!accepted);
	endtask

	// header offered while en is low, must not be taken
	task automatic hold_disabled(input logic [7:0] hdr);
		in_data <= hdr;
		in_sof <= 1'b1;
		in_eof <= 1'b0;
		in_src_rdy <= 1'b1;
		en <= 1'b0;
		repeat (12) @(posedge clk);
		en <= 1'b1;
	endtask

	// random output back-pressure, about one cycle in three
	initial
	begin
		out_dst_rdy <= 1'b0;
		forever
		begin
			@(posedge clk);
			out_dst_rdy <= ($urandom % 3) != 0;
		end
	end

	always @(posedge clk)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			finish_run(1'b1);
		end
	end

	initial
	begin
		int total_bytes;
		logic [7:0] b;
		void'($urandom(32'h3031_c3bf));
		total_bytes = 0;
		expected_out = 0;
		for (int f = 0; f < num_frames; f++)
		begin
			total_bytes += 1 + int'(frames[f].len);
			if (frames[f].hdr != 8'hFF)
				expected_out += 3 + int'(frames[f].len); // header, payload, trailer
		end
		cycle_limit = 8 * total_bytes + 200;
		rst <= 1'b1;
		en <= 1'b1;
		in_sof <= 1'b0;
		in_eof <= 1'b0;
		in_src_rdy <= 1'b0;
		in_data <= '0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		for (int f = 0; f < num_frames; f++)
		begin
			if (frames[f].pause)
				hold_disabled(frames[f].hdr);
			send_byte(frames[f].hdr, 1'b1, 1'b0);
			for (int i = 0; i < int'(frames[f].len); i++)
			begin
				b = frames[f].rnd ? 8'($urandom) : frames[f].base + 8'(i) * frames[f].step;
				send_byte(b, 1'b0, i == int'(frames[f].len) - 1);
			end
		end
		in_src_rdy <= 1'b0;
		while (out_count < expected_out)
			@(posedge clk);
		repeat (20) @(posedge clk); // room for stray extra bytes
		if (out_count != expected_out)
		begin
			local_errors++;
			$display("Got %0d output bytes instead of %0d", out_count, expected_out);
		end
		if (pending != 0)
		begin
			local_errors++;
			$display("%0d expected output bytes never came out", pending);
		end
		finish_run(1'b0);
	end

endmodule

`default_nettype wire

// File: verification/packet_checker.sv
//////////////////////////////////////////////////////////////////////
// packet processor checker
// models each accepted input frame by the forwarding rules and
// compares the output stream and port addresses against it
//////////////////////////////////////////////////////////////////////

`default_nettype none

module packet_checker
(
	input wire clk,
	input wire rst,
	input wire en,
	input wire in_sof,
	input wire in_eof,
	input wire in_src_rdy,
	input wire in_dst_rdy,
	input wire [7:0] in_data,
	input wire out_sof,
	input wire out_eof,
	input wire out_src_rdy,
	input wire out_dst_rdy,
	input wire [7:0] out_data,
	input wire [3:0] outport_addr,
	input wire [3:0] inport_addr,
	output int value_errors,
	output int other_errors,
	output int out_count, // output bytes seen
	output int pending // expected bytes not yet sent
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [9:0] exp_q [$]; // {sof, eof, byte}
	logic in_frame;
	logic dropping; // header was ff
	logic have_hi; // high half of a pair is waiting
	logic [7:0] hi_byte;
	logic [15:0] sum; // running ones' complement sum
	logic [3:0] exp_outport;
	logic [3:0] exp_inport;
	logic after_reset;

	// 16 bit ones' complement add, carry folded back in
	function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
		logic [16:0] s;
		s = {1'b0, a} + {1'b0, b};
		if (s[16])
			s = s + 17'd1;
		return s[15:0];
	endfunction

	task automatic compare_value(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected)
		begin
			value_errors++;
			$display("Fail time %0t signal %s expected %02h actual %02h", $time, name,
				expected, actual);
		end
	endtask

	// header, payload and trailer expectations from an input byte
	task automatic take_input();
		if (in_sof)
		begin
			in_frame = 1'b1;
			dropping = (in_data == 8'hFF);
			sum = '0;
			have_hi = 1'b0;
			if (!dropping)
				exp_q.push_back({2'b10, in_data});
		end
		else if (in_frame)
		begin
			if (!dropping)
				exp_q.push_back({2'b00, in_data});
			if (have_hi)
				sum = ones_add(sum, {hi_byte, in_data}); // big-endian pair
			hi_byte = in_data;
			have_hi = !have_hi;
			if (in_eof)
			begin
				in_frame = 1'b0;
				if (!dropping)
				begin
					exp_q.push_back({2'b00, ~sum[15:8]}); // trailer high first
					exp_q.push_back({2'b01, ~sum[7:0]});
				end
			end
		end
	endtask

	task automatic take_output();
		logic [9:0] e;
		out_count++;
		if (exp_q.size() == 0)
		begin
			other_errors++;
			$display("Output byte %02h at time %0t was not expected", out_data, $time);
		end
		else
		begin
			e = exp_q.pop_front();
			compare_value("out_data", e[7:0], out_data);
			compare_value("out_sof", 8'(e[9]), 8'(out_sof));
			compare_value("out_eof", 8'(e[8]), 8'(out_eof));
			if (e[9])
			begin
				exp_outport = e[3:0]; // loaded as the header leaves
				exp_inport = e[7:4];
			end
		end
	endtask

	// sampled mid-cycle, away from the driving edge
	always @(negedge clk)
	begin
		if (rst)
		begin
			exp_q.delete();
			in_frame = 1'b0;
			dropping = 1'b0;
			have_hi = 1'b0;
			hi_byte = '0;
			sum = '0;
			exp_outport = '0; // port regs clear on reset
			exp_inport = '0;
			after_reset = 1'b1;
		end
		else
		begin
			if (after_reset || !en)
			begin
				compare_value("in_dst_rdy", 8'h00, 8'(in_dst_rdy)); // sequencer idle
				compare_value("out_src_rdy", 8'h00, 8'(out_src_rdy));
			end
			after_reset = 1'b0;
			compare_value("outport_addr", 8'(exp_outport), 8'(outport_addr));
			compare_value("inport_addr", 8'(exp_inport), 8'(inport_addr));
			if (in_src_rdy && in_dst_rdy)
				take_input(); // before output, pass bytes move together
			if (out_src_rdy && out_dst_rdy)
				take_output();
		end
		pending = exp_q.size();
	end

endmodule

`default_nettype wire

// File: logic/packet_processor.sv
//////////////////////////////////////////////////////////////////////
// microcoded packet processor, top level
// sequencer plus datapath: data and operand muxes, word assembler,
// flag register and port address registers
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pp_defs.svh"

module packet_processor
	import pp_isa_pkg::*;
	import pp_ctrl_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire en,
	input wire in_sof,
	input wire in_eof,
	input wire in_src_rdy,
	output wire in_dst_rdy,
	input wire [`PP_DATA_W-1:0] in_data,
	output wire out_sof,
	output wire out_eof,
	output wire out_src_rdy,
	input wire out_dst_rdy,
	output wire [`PP_DATA_W-1:0] out_data,
	output logic [3:0] outport_addr,
	output logic [3:0] inport_addr
);

	// sequencer strobes
	logic [`PP_REG_AW-1:0] reg_addr;
	logic [1:0] reg_wen;
	logic fcs_add;
	logic fcs_clear;
	logic high_byte_en;
	logic byte_sel;
	logic flag_en;
	logic outport_en;
	logic inport_en;
	data_sel_t data_sel;
	op0_sel_t op0_sel;
	op1_sel_t op1_sel;
	alu_op_t alu_op;
	comp_mode_t comp_mode;
	logic [`PP_WORD_W-1:0] const_word;

	// datapath
	logic comp_res;
	logic fcs_check;
	logic [`PP_WORD_W-1:0] data_bus; // main mux output
	logic [`PP_WORD_W-1:0] reg_data;
	logic [`PP_WORD_W-1:0] fcs_data;
	logic [`PP_WORD_W-1:0] alu_res;
	logic [`PP_WORD_W-1:0] op0_data;
	logic [`PP_WORD_W-1:0] op1_data;
	logic [`PP_WORD_W-1:0] word_data; // {latched high, live low}
	logic [`PP_DATA_W-1:0] high_byte_q;
	logic [7:0] flag_q; // {0000, fcs_check, comp_res, eof, sof}

	pp_sequencer seq_inst (
		.clk, .rst, .en, .in_sof, .in_eof, .in_src_rdy, .out_dst_rdy, .comp_res,
		.in_dst_rdy, .out_src_rdy, .out_sof, .out_eof, .reg_addr, .reg_wen,
		.fcs_add, .fcs_clear, .high_byte_en, .byte_sel, .flag_en, .outport_en,
		.inport_en, .data_sel, .op0_sel, .op1_sel, .alu_op, .comp_mode, .const_word
	);

	pp_regfile regfile_inst (
		.clk, .rst,
		.wren_low(reg_wen[0]),
		.wren_high(reg_wen[1]),
		.address(reg_addr),
		.data_in(data_bus),
		.data_out(reg_data)
	);

	pp_checksum checksum_inst (
		.clk, .rst,
		.data_in(data_bus), // assembled word on pass_lo
		.add(fcs_add),
		.clear(fcs_clear),
		.check(fcs_check),
		.sum_out(fcs_data)
	);

	pp_alu alu_inst (
		.op0(op0_data), .op1(op1_data), .op(alu_op), .comp_mode,
		.res(alu_res), .comp_res
	);

	// word assembler, high half held from the previous byte
	always_ff @(posedge clk)
	begin
		if (high_byte_en)
			high_byte_q <= in_data;
	end
	assign word_data = {high_byte_q, in_data};

	always_comb
	begin
		case (op0_sel)
			OP0_CONST: op0_data = const_word;
			OP0_WORD:  op0_data = word_data;
			OP0_FLAGS: op0_data = `PP_WORD_W'(flag_q);
			default:   op0_data = reg_data;
		endcase
		op1_data = (op1_sel == OP1_REG) ? reg_data : const_word;
	end

	always_comb
	begin
		case (data_sel)
			SEL_CONST:    data_bus = const_word;
			SEL_CHECKSUM: data_bus = fcs_data;
			SEL_REG:      data_bus = reg_data;
			SEL_WORD:     data_bus = word_data;
			SEL_ALU:      data_bus = alu_res;
			SEL_FLAGS:    data_bus = `PP_WORD_W'(flag_q);
			SEL_INPUT:    data_bus = `PP_WORD_W'(in_data); // zero extended
			default:      data_bus = '0;
		endcase
	end

	assign out_data = byte_sel ? data_bus[`PP_WORD_W-1:`PP_DATA_W] : data_bus[`PP_DATA_W-1:0];

	// flags and port addresses
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			flag_q <= '0;
			outport_addr <= '0;
			inport_addr <= '0;
		end
		else
		begin
			if (flag_en)
				flag_q <= {4'b0000, fcs_check, comp_res, in_eof, in_sof};
			if (outport_en)
				outport_addr <= data_bus[3:0]; // header low nibble
			if (inport_en)
				inport_addr <= data_bus[7:4]; // header high nibble
		end
	end

endmodule

`default_nettype wire

// File: logic/pp_alu.sv
//////////////////////////////////////////////////////////////////////
// packet processor alu
// add, subtract, and, pass with byte masking and a zero test
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pp_defs.svh"

module pp_alu
	import pp_isa_pkg::*;
(
	input wire [`PP_WORD_W-1:0] op0,
	input wire [`PP_WORD_W-1:0] op1,
	input var alu_op_t op,
	input var comp_mode_t comp_mode,
	output logic [`PP_WORD_W-1:0] res,
	output logic comp_res
);

	logic byte_mode;
	logic [`PP_WORD_W-1:0] a;
	logic [`PP_WORD_W-1:0] b;
	logic is_zero;
	logic is_neg;

	assign byte_mode = comp_mode[2];
	// high bytes forced to zero in byte mode
	assign a = byte_mode ? `PP_WORD_W'(op0[`PP_DATA_W-1:0]) : op0;
	assign b = byte_mode ? `PP_WORD_W'(op1[`PP_DATA_W-1:0]) : op1;

	always_comb
	begin
		case (op)
			ALU_ADD: res = a + b;
			ALU_SUB: res = a - b;
			ALU_AND: res = a & b;
			default: res = a; // pass
		endcase
	end

	// byte mode tests only the low byte
	assign is_zero = byte_mode ? (res[`PP_DATA_W-1:0] == '0) : (res == '0);
	assign is_neg = byte_mode ? res[`PP_DATA_W-1] : res[`PP_WORD_W-1];

	always_comb
	begin
		case (comp_mode_t'({1'b0, comp_mode[1:0]}))
			EQ_ZERO: comp_res = is_zero;
			NE_ZERO: comp_res = !is_zero;
			LT_ZERO: comp_res = is_neg;
			default: comp_res = 1'b1; // always
		endcase
	end

endmodule

`default_nettype wire

// File: logic/pp_checksum.sv
//////////////////////////////////////////////////////////////////////
// ones' complement checksum unit
// 16 bit accumulator with end-around carry, complemented output
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pp_defs.svh"

module pp_checksum
(
	input wire clk,
	input wire rst,
	input wire [`PP_WORD_W-1:0] data_in,
	input wire add,
	input wire clear,
	output logic check, // running sum is all ones
	output logic [`PP_WORD_W-1:0] sum_out
);

	logic [`PP_WORD_W-1:0] acc_q;
	logic [`PP_WORD_W:0] raw; // sum with carry out
	logic [`PP_WORD_W-1:0] folded;

	assign raw = {1'b0, acc_q} + {1'b0, data_in};
	assign folded = raw[`PP_WORD_W-1:0] + `PP_WORD_W'(raw[`PP_WORD_W]); // end-around carry

	always_ff @(posedge clk)
	begin
		if (rst || clear)
			acc_q <= '0;
		else if (add)
			acc_q <= folded;
	end

	assign sum_out = ~acc_q; // trailer value
	assign check = &acc_q;

endmodule

`default_nettype wire

// File: logic/pp_regfile.sv
//////////////////////////////////////////////////////////////////////
// packet processor register file
// sixteen word registers, byte write enables, async read
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pp_defs.svh"

module pp_regfile
(
	input wire clk,
	input wire rst,
	input wire wren_low,
	input wire wren_high,
	input wire [`PP_REG_AW-1:0] address,
	input wire [`PP_WORD_W-1:0] data_in,
	output logic [`PP_WORD_W-1:0] data_out
);

	logic [`PP_WORD_W-1:0] regs [2**`PP_REG_AW];

	always_ff @(posedge clk)
	begin
		if (rst)
			regs <= '{default: '0};
		else
		begin
			if (wren_low)
				regs[address][`PP_DATA_W-1:0] <= data_in[`PP_DATA_W-1:0];
			if (wren_high)
				regs[address][`PP_WORD_W-1:`PP_DATA_W] <= data_in[`PP_WORD_W-1:`PP_DATA_W];
		end
	end

	assign data_out = regs[address]; // combinational read

endmodule

`default_nettype wire

// File: logic/pp_sequencer.sv
//////////////////////////////////////////////////////////////////////
// packet processor sequencer
// fixed microprogram rom, program counter, ready/stall handling
// and decode of each step into datapath strobes
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "pp_defs.svh"

module pp_sequencer
	import pp_isa_pkg::*;
	import pp_ctrl_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire en,
	input wire in_sof,
	input wire in_eof,
	input wire in_src_rdy,
	input wire out_dst_rdy,
	input wire comp_res, // from alu compare
	output logic in_dst_rdy,
	output logic out_src_rdy,
	output logic out_sof,
	output logic out_eof,
	output logic [`PP_REG_AW-1:0] reg_addr,
	output logic [1:0] reg_wen, // {high, low}
	output logic fcs_add,
	output logic fcs_clear,
	output logic high_byte_en,
	output logic byte_sel, // 1 selects bus high byte for out_data
	output logic flag_en,
	output logic outport_en,
	output logic inport_en,
	output data_sel_t data_sel,
	output op0_sel_t op0_sel,
	output op1_sel_t op1_sel,
	output alu_op_t alu_op,
	output comp_mode_t comp_mode,
	output logic [`PP_WORD_W-1:0] const_word
);

	localparam int ROM_W = 3 + `PP_PC_W; // {opcode, branch target}

	// branch is taken when the step's condition holds, else pc + 1
	localparam logic [ROM_W-1:0] ROM [`PP_ROM_DEPTH] = '{
		{IN_HDR, `PP_PC_W'(0)}, // no sof, try again
		{CMP_HDR, `PP_PC_W'(7)}, // match goes to drop
		{OUT_HDR, `PP_PC_W'(0)},
		{PASS_HI, `PP_PC_W'(0)},
		{PASS_LO, `PP_PC_W'(3)}, // no eof, next pair
		{TRL_HI, `PP_PC_W'(0)},
		{TRL_LO, `PP_PC_W'(0)}, // always back to header
		{DROP, `PP_PC_W'(7)} // stay until eof, then wrap to 0
	};

	logic [`PP_PC_W-1:0] pc_q;
	logic [`PP_PC_W-1:0] target;
	opcode_t op;
	seq_state_t state_q;
	logic active; // allowed to move bytes this cycle
	logic consume; // step takes an input byte
	logic produce; // step sends an output byte
	logic take; // branch condition
	logic done; // all transfers of the step complete

	assign op = opcode_t'(ROM[pc_q][ROM_W-1 -: 3]);
	assign target = ROM[pc_q][`PP_PC_W-1:0];
	assign active = en && (state_q != DISABLED);

	// transfer kinds and branch condition per step
	always_comb
	begin
		consume = (op == IN_HDR) || (op == DROP) || (op == PASS_HI) || (op == PASS_LO);
		produce = (op == OUT_HDR) || (op == PASS_HI) || (op == PASS_LO) ||
			(op == TRL_HI) || (op == TRL_LO);
		case (op)
			IN_HDR:  take = !in_sof; // stray byte outside a frame
			CMP_HDR: take = comp_res;
			PASS_LO: take = !in_eof;
			TRL_LO:  take = 1'b1;
			DROP:    take = !in_eof;
			default: take = 1'b0;
		endcase
	end

	// pass steps tie both sides so the byte moves in one cycle
	assign in_dst_rdy = active && consume && (!produce || out_dst_rdy);
	assign out_src_rdy = active && produce && (!consume || in_src_rdy);
	assign done = active && (!consume || in_src_rdy) && (!produce || out_dst_rdy);
	assign out_sof = active && (op == OUT_HDR);
	assign out_eof = active && (op == TRL_LO);

	// datapath strobes, writes only on completed steps
	always_comb
	begin
		reg_addr = '0; // header lives in r0
		reg_wen = 2'b00;
		fcs_add = 1'b0;
		fcs_clear = 1'b0;
		high_byte_en = 1'b0;
		byte_sel = 1'b0;
		flag_en = 1'b0;
		outport_en = 1'b0;
		inport_en = 1'b0;
		data_sel = SEL_ZERO;
		op0_sel = OP0_REG;
		op1_sel = OP1_CONST;
		alu_op = ALU_PASS;
		comp_mode = ALWAYS;
		const_word = '0;
		case (op)
			IN_HDR:
			begin
				data_sel = SEL_INPUT; // zero extended header
				reg_wen = {2{done}};
				fcs_clear = done;
			end
			CMP_HDR:
			begin
				data_sel = SEL_ALU;
				alu_op = ALU_SUB;
				comp_mode = EQ_ZERO_B; // r0 - ff == 0 means drop
				const_word = `PP_WORD_W'(8'hFF);
				flag_en = done;
			end
			OUT_HDR:
			begin
				data_sel = SEL_REG;
				outport_en = done;
				inport_en = done;
			end
			PASS_HI:
			begin
				data_sel = SEL_INPUT;
				high_byte_en = done;
			end
			PASS_LO:
			begin
				data_sel = SEL_WORD; // low byte is the live input
				fcs_add = done;
			end
			TRL_HI:
			begin
				data_sel = SEL_CHECKSUM;
				byte_sel = 1'b1;
			end
			TRL_LO:  data_sel = SEL_CHECKSUM;
			default: data_sel = SEL_ZERO; // drop, nothing on the bus
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc_q <= '0;
			state_q <= DISABLED;
		end
		else
		begin
			if (!en)
				state_q <= DISABLED;
			else if (done)
				state_q <= RUN;
			else
				state_q <= STALL;
			if (done)
				pc_q <= take ? target : `PP_PC_W'(pc_q + 1'b1); // wraps 7 -> 0
		end
	end

endmodule

`default_nettype wire

// File: logic/pp_ctrl_pkg.sv
//////////////////////////////////////////////////////////////////////
// packet processor datapath control types
// sequencer state and mux selects
//////////////////////////////////////////////////////////////////////

`default_nettype none

package pp_ctrl_pkg;

	typedef enum logic [1:0] {
		RUN      = 2'd0, // last step completed its transfers
		STALL    = 2'd1, // waiting on a ready
		DISABLED = 2'd2  // en low or just out of reset
	} seq_state_t;

	// main data bus source
	typedef enum logic [2:0] {
		SEL_CONST    = 3'd0,
		SEL_CHECKSUM = 3'd1,
		SEL_REG      = 3'd2,
		SEL_WORD     = 3'd3, // assembled high byte + live input
		SEL_ALU      = 3'd4,
		SEL_FLAGS    = 3'd5,
		SEL_INPUT    = 3'd6,
		SEL_ZERO     = 3'd7
	} data_sel_t;

	typedef enum logic [1:0] {OP0_CONST, OP0_WORD, OP0_FLAGS, OP0_REG} op0_sel_t;
	typedef enum logic {OP1_CONST, OP1_REG} op1_sel_t;

endpackage

`default_nettype wire

// File: logic/pp_isa_pkg.sv
//////////////////////////////////////////////////////////////////////
// packet processor instruction set types
// microinstruction kinds, alu operations, compare modes
//////////////////////////////////////////////////////////////////////

`default_nettype none

package pp_isa_pkg;

	// one kind per program step
	typedef enum logic [2:0] {
		IN_HDR  = 3'd0, // take header byte into r0
		CMP_HDR = 3'd1, // test header against drop value
		OUT_HDR = 3'd2, // send header, load port regs
		PASS_HI = 3'd3, // forward byte, keep as high half
		PASS_LO = 3'd4, // forward byte, sum the word
		TRL_HI  = 3'd5, // trailer high byte
		TRL_LO  = 3'd6, // trailer low byte with eof
		DROP    = 3'd7  // swallow rest of frame
	} opcode_t;

	typedef enum logic [1:0] {
		ALU_ADD  = 2'd0,
		ALU_SUB  = 2'd1,
		ALU_AND  = 2'd2,
		ALU_PASS = 2'd3 // op0 straight through
	} alu_op_t;

	// low bits pick the zero test, bit 2 selects byte mode
	typedef enum logic [2:0] {
		EQ_ZERO   = 3'b000,
		NE_ZERO   = 3'b001,
		LT_ZERO   = 3'b010,
		ALWAYS    = 3'b011,
		EQ_ZERO_B = 3'b100,
		NE_ZERO_B = 3'b101,
		LT_ZERO_B = 3'b110,
		ALWAYS_B  = 3'b111
	} comp_mode_t;

endpackage

`default_nettype wire

// File: logic/pp_defs.svh
//////////////////////////////////////////////////////////////////////
// packet processor widths
// byte, word, register address and microprogram sizes
//////////////////////////////////////////////////////////////////////

`ifndef PP_DEFS_SVH
`define PP_DEFS_SVH

// stream and datapath widths
`define PP_DATA_W 8 // one stream byte
`define PP_WORD_W 16 // datapath, register file and checksum width

// register file
`define PP_REG_AW 4 // sixteen registers

// microprogram store
`define PP_PC_W 3 // program counter bits
`define PP_ROM_DEPTH 8 // one word per program step

`endif
